//--- cpu_alu.sv
`timescale 1ns/1ps

module cpu_alu (
	input  cpu_pkg::word_t   a,
	input  cpu_pkg::word_t   b,
	input  cpu_pkg::alu_op_e op,
	output cpu_pkg::word_t   result,
	output logic             zero
);
	import cpu_pkg::*;

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			alu_sub:    result = a - b;
			alu_and:    result = a & b;
			alu_or:     result = a | b;
			alu_xor:    result = a ^ b;
			alu_sll:    result = a << shamt;
			alu_srl:    result = a >> shamt;
			alu_sra:    result = $signed(a) >>> shamt;
			alu_slt:    result = {31'b0, $signed(a) < $signed(b)};
			alu_sltu:   result = {31'b0, a < b};
			// lui goes straight through
			alu_pass_b: result = b;
			default:    result = a + b;
		endcase
	end

	assign zero = (result == 32'd0);

endmodule

//--- cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// data RAM depth in 32-bit words
`define DMEM_WORDS 256

// machine CSR addresses
`define CSR_MTVEC  12'h305
`define CSR_MEPC   12'h341
`define CSR_MCAUSE 12'h342

// environment call from M-mode
`define CAUSE_ECALL 32'd11

`endif

//--- cpu_controller.sv
`timescale 1ns/1ps

module cpu_controller (
	input  cpu_pkg::word_t     instr,
	output cpu_pkg::alu_op_e   alu_op,
	output logic               alu_src_a,
	output logic               alu_src_b,
	output cpu_pkg::imm_type_e imm_type,
	output logic               reg_write,
	output cpu_pkg::wb_sel_e   wb_sel,
	output logic               mem_read,
	output logic               mem_write,
	output cpu_pkg::mem_size_e mem_size,
	output logic               mem_unsigned,
	output cpu_pkg::csr_op_e   csr_op,
	output cpu_pkg::flow_e     flow
);
	import cpu_pkg::*;

	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_reg    = 7'b0110011;
	localparam logic [6:0] op_system = 7'b1110011;

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [11:0] funct12;

	assign opcode  = instr[6:0];
	assign funct3  = instr[14:12];
	assign funct7  = instr[31:25];
	assign funct12 = instr[31:20];

	// alt picks sub/sra; only meaningful where funct7 is part of the encoding
	function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? alu_sub : alu_add;
			3'b001:  return alu_sll;
			3'b010:  return alu_slt;
			3'b011:  return alu_sltu;
			3'b100:  return alu_xor;
			3'b101:  return alt ? alu_sra : alu_srl;
			3'b110:  return alu_or;
			default: return alu_and;
		endcase
	endfunction

	always_comb begin
		// defaults decode as a no-op
		alu_op       = alu_add;
		alu_src_a    = 1'b0;
		alu_src_b    = 1'b0;
		imm_type     = imm_i;
		reg_write    = 1'b0;
		wb_sel       = wb_alu;
		mem_read     = 1'b0;
		mem_write    = 1'b0;
		mem_size     = mem_word;
		mem_unsigned = 1'b0;
		csr_op       = csr_none;
		flow         = flow_seq;

		case (opcode)
			op_lui: begin
				alu_op    = alu_pass_b;
				alu_src_b = 1'b1;
				imm_type  = imm_u;
				reg_write = 1'b1;
			end
			op_auipc: begin
				alu_src_a = 1'b1;
				alu_src_b = 1'b1;
				imm_type  = imm_u;
				reg_write = 1'b1;
			end
			op_jal: begin
				imm_type  = imm_j;
				reg_write = 1'b1;
				wb_sel    = wb_pc_plus4;
				flow      = flow_jal;
			end
			op_jalr: begin
				reg_write = 1'b1;
				wb_sel    = wb_pc_plus4;
				flow      = flow_jalr;
			end
			op_branch: begin
				imm_type = imm_b;
				case (funct3)
					3'b000:  begin alu_op = alu_sub;  flow = flow_beq;  end
					3'b001:  begin alu_op = alu_sub;  flow = flow_bne;  end
					3'b100:  begin alu_op = alu_slt;  flow = flow_blt;  end
					3'b101:  begin alu_op = alu_slt;  flow = flow_bge;  end
					3'b110:  begin alu_op = alu_sltu; flow = flow_bltu; end
					3'b111:  begin alu_op = alu_sltu; flow = flow_bgeu; end
					default: flow = flow_seq;
				endcase
			end
			op_load, op_store: begin
				alu_src_b    = 1'b1;
				mem_unsigned = funct3[2];
				case (funct3[1:0])
					2'b00:   mem_size = mem_byte;
					2'b01:   mem_size = mem_half;
					default: mem_size = mem_word;
				endcase
				if (opcode == op_load) begin
					mem_read  = 1'b1;
					reg_write = 1'b1;
					wb_sel    = wb_load;
				end else begin
					imm_type  = imm_s;
					mem_write = 1'b1;
				end
			end
			op_imm: begin
				// srai shares funct7[5] with sub, addi must ignore it
				alu_op    = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
				alu_src_b = 1'b1;
				reg_write = 1'b1;
			end
			op_reg: begin
				alu_op    = arith_op(funct3, funct7[5]);
				reg_write = 1'b1;
			end
			op_system: begin
				case (funct3)
					3'b000: begin
						if (funct12 == 12'h000) begin
							csr_op = csr_trap;
							flow   = flow_trap;
						end else if (funct12 == 12'h302) begin
							flow = flow_ret;
						end
					end
					3'b001: begin
						csr_op    = csr_write;
						reg_write = 1'b1;
						wb_sel    = wb_csr;
					end
					3'b010: begin
						csr_op    = csr_set;
						reg_write = 1'b1;
						wb_sel    = wb_csr;
					end
					default: csr_op = csr_none;
				endcase
			end
			default: flow = flow_seq;
		endcase
	end

endmodule

//--- cpu_csr.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_csr (
	input                     clk,
	input                     reset,
	input  cpu_pkg::csr_op_e  csr_op,
	input  cpu_pkg::csr_addr_t addr,
	input  cpu_pkg::word_t    wsrc,
	input  cpu_pkg::word_t    pc,
	output cpu_pkg::word_t    rdata,
	output cpu_pkg::word_t    mtvec,
	output cpu_pkg::word_t    mepc
);
	import cpu_pkg::*;

	word_t mcause;
	word_t wval;

	// old value, also the value returned to rd
	always_comb begin
		case (addr)
			`CSR_MTVEC:  rdata = mtvec;
			`CSR_MEPC:   rdata = mepc;
			`CSR_MCAUSE: rdata = mcause;
			default:     rdata = '0;
		endcase
	end

	assign wval = (csr_op == csr_set) ? (rdata | wsrc) : wsrc;

	always_ff @(posedge clk) begin
		if (reset) begin
			mtvec  <= '0;
			mepc   <= '0;
			mcause <= '0;
		end else if (csr_op == csr_trap) begin
			mepc   <= pc;
			mcause <= `CAUSE_ECALL;
		end else if (csr_op == csr_write || csr_op == csr_set) begin
			case (addr)
				`CSR_MTVEC:  mtvec  <= wval;
				`CSR_MEPC:   mepc   <= wval;
				`CSR_MCAUSE: mcause <= wval;
				default:     mcause <= mcause;
			endcase
		end
	end

endmodule

//--- cpu_gpr.sv
`timescale 1ns/1ps

module cpu_gpr (
	input                      clk,
	input                      wen,
	input  cpu_pkg::reg_addr_t waddr,
	input  cpu_pkg::reg_addr_t raddr1,
	input  cpu_pkg::reg_addr_t raddr2,
	input  cpu_pkg::word_t     wdata,
	output cpu_pkg::word_t     rdata1,
	output cpu_pkg::word_t     rdata2
);
	import cpu_pkg::*;

	// x0 has no storage
	word_t regs [1:31];

	always_ff @(posedge clk) begin
		if (wen && waddr != 5'd0)
			regs[waddr] <= wdata;
	end

	assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

//--- cpu_imm_gen.sv
`timescale 1ns/1ps

module cpu_imm_gen (
	input  cpu_pkg::word_t     instr,
	input  cpu_pkg::imm_type_e imm_type,
	output cpu_pkg::word_t     imm
);
	import cpu_pkg::*;

	always_comb begin
		case (imm_type)
			imm_s:
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			// branch and jump offsets keep bit 0 at zero
			imm_b:
				imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			imm_u:
				imm = {instr[31:12], 12'b0};
			imm_j:
				imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			default:
				imm = {{20{instr[31]}}, instr[31:20]};
		endcase
	end

endmodule

//--- cpu_lsu.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_lsu (
	input                      clk,
	input                      reset,
	input  logic               read,
	input  logic               write,
	input  cpu_pkg::mem_size_e size,
	input  logic               unsigned_load,
	input  cpu_pkg::word_t     addr,
	input  cpu_pkg::word_t     wdata,
	output cpu_pkg::word_t     rdata
);
	import cpu_pkg::*;

	localparam int idx_w = $clog2(`DMEM_WORDS);

	word_t            ram [0:`DMEM_WORDS-1];
	logic [idx_w-1:0] idx;
	logic [1:0]       offset;
	logic [3:0]       base_en;
	logic [3:0]       byte_en;
	word_t            lane_data;
	word_t            shifted;

	// upper address bits wrap around the RAM
	assign idx    = addr[idx_w+1:2];
	assign offset = addr[1:0];

	always_comb begin
		case (size)
			mem_byte: base_en = 4'b0001;
			mem_half: base_en = 4'b0011;
			default:  base_en = 4'b1111;
		endcase
	end

	assign byte_en   = base_en << offset;
	assign lane_data = wdata << {offset, 3'b000};

	always_ff @(posedge clk) begin
		if (write && !reset) begin
			for (int i = 0; i < 4; i++) begin
				if (byte_en[i])
					ram[idx][8*i +: 8] <= lane_data[8*i +: 8];
			end
		end
	end

	// bring the addressed bytes down to bit 0
	assign shifted = ram[idx] >> {offset, 3'b000};

	always_comb begin
		if (!read)
			rdata = '0;
		else begin
			case (size)
				mem_byte: rdata = {{24{~unsigned_load & shifted[7]}}, shifted[7:0]};
				mem_half: rdata = {{16{~unsigned_load & shifted[15]}}, shifted[15:0]};
				default:  rdata = shifted;
			endcase
		end
	end

endmodule

//--- cpu_pc_unit.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_pc_unit (
	input                  clk,
	input                  reset,
	input  cpu_pkg::flow_e flow,
	input  cpu_pkg::word_t imm,
	input  cpu_pkg::word_t rs1_data,
	input  cpu_pkg::word_t mtvec,
	input  cpu_pkg::word_t mepc,
	input  logic           alu_zero,
	input  logic           alu_lsb,
	output cpu_pkg::word_t pc,
	output cpu_pkg::word_t pc_plus4
);
	import cpu_pkg::*;

	word_t next_pc;
	word_t jalr_target;
	logic  taken;

	assign pc_plus4    = pc + 32'd4;
	assign jalr_target = (rs1_data + imm) & ~32'd1;

	// alu_lsb holds the slt/sltu result for the ordered compares
	always_comb begin
		case (flow)
			flow_beq:  taken = alu_zero;
			flow_bne:  taken = ~alu_zero;
			flow_blt:  taken = alu_lsb;
			flow_bge:  taken = ~alu_lsb;
			flow_bltu: taken = alu_lsb;
			flow_bgeu: taken = ~alu_lsb;
			default:   taken = 1'b0;
		endcase
	end

	always_comb begin
		case (flow)
			flow_jal:  next_pc = pc + imm;
			flow_jalr: next_pc = jalr_target;
			flow_trap: next_pc = mtvec;
			flow_ret:  next_pc = mepc;
			default:   next_pc = taken ? pc + imm : pc_plus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			pc <= `RESET_PC;
		else
			pc <= next_pc;
	end

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

	// datapath widths
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [11:0] csr_addr_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_slt,
		alu_sltu,
		alu_pass_b
	} alu_op_e;

	typedef enum logic [2:0] {
		imm_i,
		imm_s,
		imm_b,
		imm_u,
		imm_j
	} imm_type_e;

	// register write-back source
	typedef enum logic [2:0] {
		wb_alu,
		wb_pc_plus4,
		wb_load,
		wb_csr
	} wb_sel_e;

	typedef enum logic [1:0] {
		csr_none,
		csr_write,
		csr_set,
		csr_trap
	} csr_op_e;

	// next-pc kind, one per control transfer
	typedef enum logic [3:0] {
		flow_seq,
		flow_jal,
		flow_jalr,
		flow_beq,
		flow_bne,
		flow_blt,
		flow_bge,
		flow_bltu,
		flow_bgeu,
		flow_trap,
		flow_ret
	} flow_e;

	typedef enum logic [1:0] {
		mem_byte,
		mem_half,
		mem_word
	} mem_size_e;

endpackage

//--- cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
	input                      clk,
	input                      reset,
	output cpu_pkg::word_t     imem_addr,
	input  cpu_pkg::word_t     imem_data,
	output cpu_pkg::word_t     retire_pc,
	output logic               wb_en,
	output cpu_pkg::reg_addr_t wb_addr,
	output cpu_pkg::word_t     wb_data
);
	import cpu_pkg::*;

	// control selects
	alu_op_e   alu_op;
	logic      alu_src_a;
	logic      alu_src_b;
	imm_type_e imm_type;
	logic      reg_write;
	wb_sel_e   wb_sel;
	logic      mem_read;
	logic      mem_write;
	mem_size_e mem_size;
	logic      mem_unsigned;
	csr_op_e   csr_op;
	flow_e     flow;

	// datapath
	word_t     pc;
	word_t     pc_plus4;
	word_t     imm;
	word_t     rs1_data;
	word_t     rs2_data;
	word_t     alu_a;
	word_t     alu_b;
	word_t     alu_result;
	logic      alu_zero;
	word_t     load_data;
	word_t     csr_rdata;
	word_t     mtvec;
	word_t     mepc;
	reg_addr_t rd;
	csr_addr_t csr_addr;

	assign imem_addr = pc;
	assign rd        = imem_data[11:7];
	assign csr_addr  = imem_data[31:20];

	cpu_controller controller (
		.instr(imem_data), .alu_op(alu_op), .alu_src_a(alu_src_a), .alu_src_b(alu_src_b),
		.imm_type(imm_type), .reg_write(reg_write), .wb_sel(wb_sel),
		.mem_read(mem_read), .mem_write(mem_write), .mem_size(mem_size),
		.mem_unsigned(mem_unsigned), .csr_op(csr_op), .flow(flow)
	);

	cpu_pc_unit pc_unit (
		.clk(clk), .reset(reset), .flow(flow), .imm(imm), .rs1_data(rs1_data),
		.mtvec(mtvec), .mepc(mepc), .alu_zero(alu_zero), .alu_lsb(alu_result[0]),
		.pc(pc), .pc_plus4(pc_plus4)
	);

	cpu_gpr gpr (
		.clk(clk), .wen(wb_en), .waddr(rd), .raddr1(imem_data[19:15]),
		.raddr2(imem_data[24:20]), .wdata(wb_data), .rdata1(rs1_data), .rdata2(rs2_data)
	);

	cpu_csr csr (
		.clk(clk), .reset(reset), .csr_op(csr_op), .addr(csr_addr), .wsrc(rs1_data),
		.pc(pc), .rdata(csr_rdata), .mtvec(mtvec), .mepc(mepc)
	);

	cpu_imm_gen imm_gen (.instr(imem_data), .imm_type(imm_type), .imm(imm));

	// alu operand selects
	assign alu_a = alu_src_a ? pc : rs1_data;
	assign alu_b = alu_src_b ? imm : rs2_data;

	cpu_alu alu (.a(alu_a), .b(alu_b), .op(alu_op), .result(alu_result), .zero(alu_zero));

	cpu_lsu lsu (
		.clk(clk), .reset(reset), .read(mem_read), .write(mem_write), .size(mem_size),
		.unsigned_load(mem_unsigned), .addr(alu_result), .wdata(rs2_data), .rdata(load_data)
	);

	always_comb begin
		case (wb_sel)
			wb_pc_plus4: wb_data = pc_plus4;
			wb_load:     wb_data = load_data;
			wb_csr:      wb_data = csr_rdata;
			default:     wb_data = alu_result;
		endcase
	end

	// retire port, x0 writes never show
	assign retire_pc = pc;
	assign wb_addr   = rd;
	assign wb_en     = reg_write && !reset && (rd != 5'd0);

endmodule

//--- project.f
+incdir+.
cpu_pkg.sv
cpu_controller.sv
cpu_pc_unit.sv
cpu_gpr.sv
cpu_csr.sv
cpu_imm_gen.sv
cpu_alu.sv
cpu_lsu.sv
cpu_top.sv
tb_cpu.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f project.f --top-module tb_cpu -o tb_cpu
./obj_dir/tb_cpu > sim.log
cat sim.log
if grep -q "Done: errors found" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

//--- tb_cpu_model.svh
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

localparam logic [6:0] op_lui    = 7'b0110111;
localparam logic [6:0] op_auipc  = 7'b0010111;
localparam logic [6:0] op_jalr   = 7'b1100111;
localparam logic [6:0] op_load   = 7'b0000011;
localparam logic [6:0] op_imm    = 7'b0010011;
localparam logic [6:0] op_reg    = 7'b0110011;
localparam logic [6:0] op_system = 7'b1110011;

// reference state, separate from the DUT
logic [31:0] m_x [0:31];
logic [31:0] m_pc;
logic [31:0] m_mtvec;
logic [31:0] m_mepc;
logic [31:0] m_mcause;
logic [7:0]  m_mem [0:`DMEM_WORDS*4-1];

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, op_reg};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
	return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
	return {imm, rd, op};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
	return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

// sub and sra use the alt bit, everything else ignores it
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
	case (f3)
		3'd0:    return alt ? a - b : a + b;
		3'd1:    return a << b[4:0];
		3'd2:    return {31'd0, $signed(a) < $signed(b)};
		3'd3:    return {31'd0, a < b};
		3'd4:    return a ^ b;
		3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
		3'd6:    return a | b;
		default: return a & b;
	endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
	case (f3)
		3'd0:    return a == b;
		3'd1:    return a != b;
		3'd4:    return $signed(a) < $signed(b);
		3'd5:    return $signed(a) >= $signed(b);
		3'd6:    return a < b;
		3'd7:    return a >= b;
		default: return 1'b0;
	endcase
endfunction

function automatic int byte_idx(input logic [31:0] a);
	return int'(a % (`DMEM_WORDS * 4));
endfunction

function automatic logic [31:0] load_ref(input logic [31:0] addr, input logic [2:0] f3);
	logic [31:0] w;
	w = '0;
	for (int k = 3; k >= 0; k--)
		w = {w[23:0], m_mem[byte_idx(addr + 32'(k))]};
	case (f3)
		3'd0:    return {{24{w[7]}}, w[7:0]};
		3'd1:    return {{16{w[15]}}, w[15:0]};
		3'd4:    return {24'd0, w[7:0]};
		3'd5:    return {16'd0, w[15:0]};
		default: return w;
	endcase
endfunction

task automatic store_ref(input logic [31:0] addr, input logic [2:0] f3,
		input logic [31:0] data);
	int n;
	n = 1 << f3[1:0];
	for (int k = 0; k < n; k++)
		m_mem[byte_idx(addr + 32'(k))] = data[8*k +: 8];
endtask

function automatic logic [31:0] csr_value(input logic [11:0] addr);
	case (addr)
		`CSR_MTVEC:  return m_mtvec;
		`CSR_MEPC:   return m_mepc;
		`CSR_MCAUSE: return m_mcause;
		default:     return 32'd0;
	endcase
endfunction

task automatic csr_store(input logic [11:0] addr, input logic [31:0] v);
	case (addr)
		`CSR_MTVEC:  m_mtvec = v;
		`CSR_MEPC:   m_mepc = v;
		`CSR_MCAUSE: m_mcause = v;
		default:     m_mcause = m_mcause;
	endcase
endtask

// executes one instruction and predicts the retire port
task automatic model_step(output logic [31:0] e_pc, output logic e_en,
		output logic [4:0] e_rd, output logic [31:0] e_data);
	logic [31:0] ins;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm_i;
	logic [31:0] res;
	logic [31:0] npc;
	logic        wr;
	ins   = prog[m_pc[10:2]];
	a     = m_x[ins[19:15]];
	b     = m_x[ins[24:20]];
	imm_i = {{20{ins[31]}}, ins[31:20]};
	npc   = m_pc + 32'd4;
	res   = '0;
	wr    = 1'b0;
	case (ins[6:0])
		op_lui: begin
			res = {ins[31:12], 12'd0};
			wr  = 1'b1;
		end
		op_auipc: begin
			res = m_pc + {ins[31:12], 12'd0};
			wr  = 1'b1;
		end
		7'b1101111: begin
			res = m_pc + 32'd4;
			wr  = 1'b1;
			npc = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		end
		op_jalr: begin
			res = m_pc + 32'd4;
			wr  = 1'b1;
			npc = (a + imm_i) & ~32'd1;
		end
		7'b1100011: begin
			if (branch_taken(ins[14:12], a, b))
				npc = m_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		end
		op_load: begin
			res = load_ref(a + imm_i, ins[14:12]);
			wr  = 1'b1;
		end
		7'b0100011: store_ref(a + {{20{ins[31]}}, ins[31:25], ins[11:7]}, ins[14:12], b);
		op_imm: begin
			res = alu_ref(ins[14:12], ins[14:12] == 3'd5 && ins[30], a, imm_i);
			wr  = 1'b1;
		end
		op_reg: begin
			res = alu_ref(ins[14:12], ins[30], a, b);
			wr  = 1'b1;
		end
		op_system: begin
			res = csr_value(ins[31:20]);
			if (ins[14:12] == 3'd0 && ins[31:20] == 12'h000) begin
				m_mepc   = m_pc;
				m_mcause = `CAUSE_ECALL;
				npc      = m_mtvec;
			end else if (ins[14:12] == 3'd0 && ins[31:20] == 12'h302) begin
				npc = m_mepc;
			end else if (ins[14:12] == 3'd1) begin
				wr = 1'b1;
				csr_store(ins[31:20], a);
			end else if (ins[14:12] == 3'd2) begin
				wr = 1'b1;
				csr_store(ins[31:20], res | a);
			end
		end
		default: wr = 1'b0;
	endcase
	e_pc   = m_pc;
	e_en   = wr && ins[11:7] != 5'd0;
	e_rd   = ins[11:7];
	e_data = res;
	if (e_en)
		m_x[ins[11:7]] = res;
	m_pc = npc;
endtask

`endif

//--- tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb_cpu;
	import cpu_pkg::*;

	logic      clk;
	logic      reset;
	word_t     imem_addr;
	word_t     imem_data;
	word_t     retire_pc;
	logic      wb_en;
	reg_addr_t wb_addr;
	word_t     wb_data;

	logic [31:0] prog [0:511];
	int          prog_len;
	int          n;
	logic [31:0] end_pc;
	int          sec_start [0:4];
	string       sec_name [0:4];
	int          sec_err [0:4];
	int          cur_sec;
	int          errors;
	int          checks;
	int          reset_err;
	logic        first;
	logic        done;
	logic [31:0] e_pc;
	logic        e_en;
	logic [4:0]  e_rd;
	logic [31:0] e_data;

	`include "tb_cpu_model.svh"

	// instruction port answers in the same cycle
	assign imem_data = prog[imem_addr[10:2]];

	cpu_top uut (
		.clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
		.retire_pc(retire_pc), .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic put(input logic [31:0] ins);
		prog[n] = ins;
		n++;
	endtask

	task automatic build_program();
		logic [31:0] r;
		logic [2:0]  f3;
		logic        alt;
		int          h;
		for (int i = 0; i < 512; i++)
			prog[i] = enc_j(21'd0, 5'd0);
		n = 0;
		sec_name[0] = "alu";
		sec_start[0] = 0;
		for (int i = 1; i < 32; i++) begin
			r = $urandom;
			put(enc_u(r[31:12], 5'(i), op_lui));
			put(enc_i(r[11:0], 5'(i), 3'd0, 5'(i), op_imm));
		end
		for (int i = 0; i < 40; i++) begin
			r = $urandom;
			f3 = r[2:0];
			alt = r[3] && (f3 == 3'd5 || (f3 == 3'd0 && r[4]));
			if (r[4])
				put(enc_r({1'b0, alt, 5'd0}, r[9:5], r[14:10], f3, r[19:15]));
			else if (f3 == 3'd1 || f3 == 3'd5)
				put(enc_i({1'b0, alt, 5'd0, r[24:20]}, r[14:10], f3, r[19:15], op_imm));
			else
				put(enc_i(r[31:20], r[14:10], f3, r[19:15], op_imm));
		end
		// every funct3 with fixed destinations so sub, sra and srai always occur
		for (int f = 0; f < 8; f++) begin
			for (int v = 0; v < 2; v++) begin
				if (v == 1 && f != 0 && f != 5)
					continue;
				r = $urandom;
				alt = (v == 1);
				put(enc_r({1'b0, alt, 5'd0}, r[9:5], r[14:10], 3'(f), 5'd21));
				if (f == 1 || f == 5)
					put(enc_i({1'b0, alt, 5'd0, r[24:20]}, r[14:10], 3'(f), 5'd22, op_imm));
				else if (!alt)
					put(enc_i(r[31:20], r[14:10], 3'(f), 5'd22, op_imm));
			end
		end
		// x0 as destination
		put(enc_i(12'h123, 5'd1, 3'd0, 5'd0, op_imm));
		put(enc_r(7'd0, 5'd2, 5'd1, 3'd0, 5'd0));
		sec_name[1] = "upper";
		sec_start[1] = n * 4;
		for (int i = 0; i < 4; i++) begin
			r = $urandom;
			put(enc_u(r[31:12], r[4:0], op_lui));
			put(enc_u(r[31:12], r[9:5], op_auipc));
		end
		sec_name[2] = "branch";
		sec_start[2] = n * 4;
		// operands differ in every upper bit so signed and unsigned order disagree
		r = $urandom;
		put(enc_u(r[31:12], 5'd1, op_lui));
		put(enc_u(~r[31:12], 5'd2, op_lui));
		for (int i = 0; i < 8; i++) begin
			if (i == 2 || i == 3)
				continue;
			put(enc_b(13'd8, 5'd2, 5'd1, 3'(i)));
			put(enc_i(12'h7ff, 5'd0, 3'd0, 5'd20, op_imm));
			put(enc_b(13'd8, 5'd3, 5'd3, 3'(i)));
			put(enc_i(12'h7fe, 5'd0, 3'd0, 5'd20, op_imm));
			put(enc_b(13'd8, 5'd1, 5'd2, 3'(i)));
			put(enc_i(12'h7fb, 5'd0, 3'd0, 5'd20, op_imm));
		end
		put(enc_j(21'd8, 5'd5));
		put(enc_i(12'h7fd, 5'd0, 3'd0, 5'd20, op_imm));
		put(enc_u(20'd0, 5'd6, op_auipc));
		put(enc_i(12'd12, 5'd6, 3'd0, 5'd7, op_jalr));
		put(enc_i(12'h7fc, 5'd0, 3'd0, 5'd20, op_imm));
		sec_name[3] = "load/store";
		sec_start[3] = n * 4;
		put(enc_i(12'h100, 5'd0, 3'd0, 5'd10, op_imm));
		for (int w = 0; w < 2; w++) begin
			put(enc_s(12'(w * 4), 5'd1, 5'd10, 3'd2));
			put(enc_i(12'(w * 4), 5'd10, 3'd2, 5'd25, op_load));
			for (int k = 0; k < 4; k++)
				put(enc_s(12'(w * 4 + k), 5'(11 + k), 5'd10, 3'd0));
			put(enc_i(12'(w * 4), 5'd10, 3'd2, 5'd20, op_load));
			for (int k = 0; k < 4; k++) begin
				put(enc_i(12'(w * 4 + k), 5'd10, 3'd0, 5'd21, op_load));
				put(enc_i(12'(w * 4 + k), 5'd10, 3'd4, 5'd22, op_load));
			end
			put(enc_s(12'(w * 4), 5'd15, 5'd10, 3'd1));
			put(enc_s(12'(w * 4 + 2), 5'd16, 5'd10, 3'd1));
			for (int k = 0; k < 4; k += 2) begin
				put(enc_i(12'(w * 4 + k), 5'd10, 3'd1, 5'd23, op_load));
				put(enc_i(12'(w * 4 + k), 5'd10, 3'd5, 5'd24, op_load));
			end
		end
		sec_name[4] = "csr/trap";
		sec_start[4] = n * 4;
		h = (n + 5) * 4;
		put(enc_i(12'(h), 5'd0, 3'd0, 5'd12, op_imm));
		put(enc_i(`CSR_MTVEC, 5'd12, 3'd1, 5'd13, op_system));
		put(enc_i(`CSR_MTVEC, 5'd0, 3'd2, 5'd14, op_system));
		put(32'h0000_0073);
		put(enc_j(21'd24, 5'd0));
		// trap handler steps mepc past the ecall
		put(enc_i(`CSR_MCAUSE, 5'd0, 3'd2, 5'd15, op_system));
		put(enc_i(`CSR_MEPC, 5'd0, 3'd2, 5'd16, op_system));
		put(enc_i(12'd4, 5'd16, 3'd0, 5'd16, op_imm));
		put(enc_i(`CSR_MEPC, 5'd16, 3'd1, 5'd0, op_system));
		put(32'h3020_0073);
		put(enc_i(`CSR_MTVEC, 5'd1, 3'd2, 5'd17, op_system));
		put(enc_i(`CSR_MTVEC, 5'd0, 3'd2, 5'd18, op_system));
		end_pc = n * 4;
		put(enc_j(21'd0, 5'd0));
		prog_len = n;
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		if (got !== exp) begin
			$display("FAIL %s pc %h exp %h got %h", name, e_pc, exp, got);
			errors++;
			sec_err[cur_sec]++;
		end
	endtask

	task automatic report_section(input int s);
		$display("test %s: %0d errors", sec_name[s], sec_err[s]);
	endtask

	always @(negedge clk) begin
		if (reset) begin
			checks++;
			if (wb_en !== 1'b0) begin
				$display("FAIL wb_en during reset exp %h got %h", 1'b0, wb_en);
				errors++;
				reset_err++;
			end
		end else if (!done) begin
			if (first) begin
				checks++;
				if (retire_pc !== `RESET_PC) begin
					$display("FAIL retire_pc after reset exp %h got %h", `RESET_PC, retire_pc);
					errors++;
					reset_err++;
				end
				$display("test reset: %0d errors", reset_err);
				first = 1'b0;
			end
			model_step(e_pc, e_en, e_rd, e_data);
			while (cur_sec < 4 && e_pc >= 32'(sec_start[cur_sec + 1])) begin
				report_section(cur_sec);
				cur_sec++;
			end
			check_word("imem_addr", e_pc, imem_addr);
			check_word("retire_pc", e_pc, retire_pc);
			check_word("wb_en", {31'd0, e_en}, {31'd0, wb_en});
			if (e_en) begin
				check_word("wb_addr", {27'd0, e_rd}, {27'd0, wb_addr});
				check_word("wb_data", e_data, wb_data);
			end
			if (e_pc == end_pc) begin
				report_section(cur_sec);
				done = 1'b1;
			end
		end
	end

	initial begin
		reset = 1'b1;
		done = 1'b0;
		first = 1'b1;
		errors = 0;
		checks = 0;
		reset_err = 0;
		cur_sec = 0;
		prog_len = 0;
		m_pc = `RESET_PC;
		m_mtvec = '0;
		m_mepc = '0;
		m_mcause = '0;
		for (int i = 0; i < 32; i++)
			m_x[i] = '0;
		for (int i = 0; i < `DMEM_WORDS * 4; i++)
			m_mem[i] = '0;
		for (int i = 0; i < 5; i++)
			sec_err[i] = 0;
		void'($urandom(76372));
		build_program();
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		wait (done);
		@(posedge clk);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// twice the time of the straight-line program plus reset
	initial begin
		wait (prog_len > 0);
		#((prog_len + 4) * 40 * 2);
		$display("timeout before the program reached its end");
		$display("Done: errors found");
		$finish;
	end

endmodule
